//--- ooo_issue.f
+incdir+source
source/ooo_issue_pkg.sv
source/inst_decode.sv
source/rs_entry.sv
source/rs_issue.sv
source/fu_execute.sv
source/result_regfile.sv
source/ooo_issue_top.sv
tests/tb_ooo_issue.sv

//--- Bender.yml
package:
  name: ooo_issue

sources:
  - include_dirs:
      - source
    files:
      - source/ooo_issue_pkg.sv
      - source/inst_decode.sv
      - source/rs_entry.sv
      - source/rs_issue.sv
      - source/fu_execute.sv
      - source/result_regfile.sv
      - source/ooo_issue_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_ooo_issue.sv

//--- tests/tb_ooo_issue.sv
// Testbench for the issue slice that checks each CDB tag against an in-order model
`timescale 1ns/1ps
`include "ooo_issue_cfg.svh"
module tb_ooo_issue;

    logic        clk_i = 1'b0;
    logic        reset_i = 1'b1;
    logic        inst_valid_i = 1'b0;
    logic [31:0] inst_i = 32'h0;
    logic        stall_o;
    logic        cdb_valid_o;
    logic [4:0]  cdb_tag_o;
    logic [31:0] cdb_data_o;

    // Table columns are the instruction word, a broadcast flag, a stall flag
    // and a flag that forbids an idle cycle before the entry
    logic [31:0] tbl_inst [$];
    bit          tbl_bc [$];
    bit          tbl_st [$];
    bit          tbl_tight [$];

    logic [31:0] ref_regs [32];
    logic [31:0] exp_q [32][$];
    logic [31:0] popped;
    int          errors = 0;
    int          bcast_count = 0;
    int          exp_bcasts = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    bit          driving_started = 1'b0;

    ooo_issue_top UUT (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .stall_o      (stall_o),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_data_o   (cdb_data_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic push_entry(input logic [31:0] w, input bit bc, input bit st,
                              input bit tight);
        tbl_inst.push_back(w);
        tbl_bc.push_back(bc);
        tbl_st.push_back(st);
        tbl_tight.push_back(tight);
    endtask

    task automatic build_table();
        // Seed registers from x0
        push_entry(enc_i(3'b000, 5'd1, 5'd0, 12'd5), 1, 0, 0);
        push_entry(enc_i(3'b000, 5'd2, 5'd0, 12'hffd), 1, 0, 0);
        push_entry(enc_i(3'b000, 5'd3, 5'd0, 12'h123), 1, 0, 0);
        push_entry(enc_i(3'b000, 5'd4, 5'd0, 12'h7ff), 1, 0, 0);
        // Independent ALU ops
        push_entry(enc_r(7'h00, 3'b000, 5'd5, 5'd1, 5'd2), 1, 0, 0);
        push_entry(enc_r(7'h20, 3'b000, 5'd6, 5'd3, 5'd1), 1, 0, 0);
        push_entry(enc_r(7'h00, 3'b111, 5'd7, 5'd3, 5'd4), 1, 0, 0);
        push_entry(enc_r(7'h00, 3'b110, 5'd8, 5'd1, 5'd3), 1, 0, 0);
        push_entry(enc_r(7'h00, 3'b100, 5'd9, 5'd4, 5'd2), 1, 0, 0);
        // ADDI into MUL into ADD
        // x11 wakes up on the CDB and x12 reads x10 in the cycle it is broadcast
        push_entry(enc_i(3'b000, 5'd10, 5'd1, 12'd7), 1, 0, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd11, 5'd10, 5'd10), 1, 0, 1);
        push_entry(enc_r(7'h00, 3'b000, 5'd12, 5'd10, 5'd1), 1, 0, 1);
        push_entry(enc_r(7'h00, 3'b000, 5'd26, 5'd11, 5'd1), 1, 0, 0);
        // MUL next to independent ALU ops
        push_entry(enc_r(7'h01, 3'b000, 5'd13, 5'd4, 5'd2), 1, 0, 0);
        push_entry(enc_r(7'h00, 3'b000, 5'd14, 5'd1, 5'd1), 1, 0, 0);
        push_entry(enc_r(7'h00, 3'b100, 5'd15, 5'd3, 5'd1), 1, 0, 0);
        // Dependent MUL chain, then a fan-out that fills the MUL station
        push_entry(enc_r(7'h01, 3'b000, 5'd16, 5'd13, 5'd11), 1, 0, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd17, 5'd16, 5'd2), 1, 0, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd18, 5'd17, 5'd3), 1, 0, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd19, 5'd18, 5'd1), 1, 0, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd20, 5'd19, 5'd4), 1, 0, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd21, 5'd20, 5'd1), 1, 0, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd22, 5'd20, 5'd2), 1, 0, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd23, 5'd20, 5'd3), 1, 0, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd24, 5'd20, 5'd4), 1, 1, 0);
        push_entry(enc_r(7'h01, 3'b000, 5'd25, 5'd20, 5'd5), 1, 0, 0);
        // Destination still busy
        push_entry(enc_r(7'h00, 3'b000, 5'd25, 5'd1, 5'd2), 1, 1, 0);
        // Dropped entries with rd x0, SLL, a load, NOP and XORI
        push_entry(enc_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd2), 0, 0, 0);
        push_entry(enc_r(7'h00, 3'b001, 5'd25, 5'd1, 5'd2), 0, 0, 0);
        push_entry({12'h0, 5'd0, 3'b010, 5'd1, 7'b0000011}, 0, 0, 0);
        push_entry(enc_i(3'b000, 5'd0, 5'd0, 12'd0), 0, 0, 0);
        push_entry(enc_i(3'b100, 5'd4, 5'd1, 12'h0f0), 0, 0, 0);
        // Tail reads the late results
        push_entry(enc_r(7'h00, 3'b000, 5'd27, 5'd25, 5'd24), 1, 0, 0);
        push_entry(enc_i(3'b000, 5'd28, 5'd27, 12'hfff), 1, 0, 0);
    endtask

    // In-order RV32 semantics for the supported subset
    task automatic model_step(input int idx, input logic [31:0] w, input bit bc);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        bit          legal;
        rd = w[11:7];
        a = ref_regs[w[19:15]];
        b = ref_regs[w[24:20]];
        v = 32'h0;
        legal = 1'b1;
        if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
            v = a + {{20{w[31]}}, w[31:20]};
        end else if (w[6:0] == 7'b0110011) begin
            case ({w[31:25], w[14:12]})
                10'b0000000_000: v = a + b;
                10'b0100000_000: v = a - b;
                10'b0000000_111: v = a & b;
                10'b0000000_110: v = a | b;
                10'b0000000_100: v = a ^ b;
                10'b0000001_000: v = a * b;
                default: legal = 1'b0;
            endcase
        end else begin
            legal = 1'b0;
        end
        if (rd == 5'd0) legal = 1'b0;
        if (legal != bc) begin
            $display("table entry %0d is marked inconsistently with the model", idx);
            errors++;
        end
        if (legal) begin
            ref_regs[rd] = v;
            exp_q[rd].push_back(v);
            exp_bcasts++;
        end
    endtask

    // Run limit
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: stopped after %0d cycles with %0d of %0d broadcasts seen",
                     cycle_count, bcast_count, exp_bcasts);
            $display("Result: FAILED");
            $finish;
        end
    end

    // CDB monitor sampled mid-cycle
    always @(negedge clk_i) begin
        if (!reset_i && cdb_valid_o === 1'b1) begin
            bcast_count++;
            if (!driving_started) begin
                $display("error at %0t: broadcast on tag %0d before any instruction",
                         $time, cdb_tag_o);
                errors++;
            end else if (cdb_tag_o == 5'd0) begin
                $display("error at %0t: broadcast on tag 0", $time);
                errors++;
            end else if (exp_q[cdb_tag_o].size() == 0) begin
                $display("error at %0t: unexpected broadcast on tag %0d data %h",
                         $time, cdb_tag_o, cdb_data_o);
                errors++;
            end else begin
                popped = exp_q[cdb_tag_o].pop_front();
                if (cdb_data_o !== popped) begin
                    $display("error at %0t: tag %0d data %h, expected %h",
                             $time, cdb_tag_o, cdb_data_o, popped);
                    errors++;
                end
            end
        end
    end

    initial begin
        int stall_cycles;
        void'($urandom(32'hf1b3));
        for (int r = 0; r < 32; r++) ref_regs[r] = 32'h0;
        build_table();
        for (int k = 0; k < tbl_inst.size(); k++) model_step(k, tbl_inst[k], tbl_bc[k]);
        cycle_limit = tbl_inst.size() * (`OOO_MUL_STAGES + 8) + 50;

        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        if (cdb_valid_o !== 1'b0 || stall_o !== 1'b0) begin
            $display("error at %0t: cdb_valid_o %b stall_o %b after reset",
                     $time, cdb_valid_o, stall_o);
            errors++;
        end
        // Quiet period with no instruction in flight
        repeat (3) @(posedge clk_i);

        for (int i = 0; i < tbl_inst.size(); i++) begin
            if (!tbl_tight[i] && $urandom % 4 == 0) begin
                @(posedge clk_i);
                inst_valid_i <= 1'b0;
            end
            @(posedge clk_i);
            inst_valid_i <= 1'b1;
            inst_i <= tbl_inst[i];
            driving_started = 1'b1;
            stall_cycles = 0;
            @(negedge clk_i);
            while (stall_o) begin
                if (!tbl_bc[i]) begin
                    $display("error at %0t: dropped entry %0d raised stall", $time, i);
                    errors++;
                end
                stall_cycles++;
                @(negedge clk_i);
            end
            if (tbl_st[i] && stall_cycles == 0) begin
                $display("error at %0t: entry %0d was accepted without the expected stall",
                         $time, i);
                errors++;
            end
        end
        // Accept edge of the last entry
        @(posedge clk_i);
        inst_valid_i <= 1'b0;

        while (bcast_count < exp_bcasts) @(posedge clk_i);
        repeat (10) @(posedge clk_i);

        if (bcast_count != exp_bcasts) begin
            $display("broadcast count %0d does not match the %0d legal instructions",
                     bcast_count, exp_bcasts);
            errors++;
        end
        for (int r = 0; r < 32; r++) begin
            if (exp_q[r].size() != 0) begin
                $display("register %0d still has %0d results outstanding", r, exp_q[r].size());
                errors++;
            end
        end

        $display("summary: %0d instructions, %0d broadcasts, %0d expected, %0d errors",
                 tbl_inst.size(), bcast_count, exp_bcasts, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- source/ooo_issue_top.sv
// Issue slice top, decode into two stations feeding execute and writeback
`timescale 1ns/1ps
module ooo_issue_top import ooo_issue_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        inst_valid_i,
    input  rv_inst_u    inst_i,
    output logic        stall_o,
    output logic        cdb_valid_o,
    output logic [4:0]  cdb_tag_o,
    output logic [31:0] cdb_data_o
);
    logic [4:0]  rs1_addr, rs2_addr, rd_addr;
    logic [31:0] rs1_val, rs2_val;
    logic        rs1_rdy, rs2_rdy, busy_rd;
    logic        alu_free, mul_free, alu_alloc, mul_alloc, set_busy;
    alu_op_e     dec_op, alu_op;
    logic [31:0] opa, opb;
    logic        opa_rdy, opb_rdy;
    logic [4:0]  opa_tag, opb_tag;
    logic        alu_issue, mul_issue, mul_near_done;
    logic [31:0] alu_a, alu_b, mul_a, mul_b;
    logic [4:0]  alu_rd, mul_rd;
    logic        res_valid;
    logic [4:0]  res_tag;
    logic [31:0] res_data;

    inst_decode u_decode (
        .inst_valid_i (inst_valid_i), .inst_i      (inst_i),
        .rs1_val_i    (rs1_val),      .rs1_rdy_i   (rs1_rdy),
        .rs2_val_i    (rs2_val),      .rs2_rdy_i   (rs2_rdy),
        .busy_rd_i    (busy_rd),      .alu_free_i  (alu_free),
        .mul_free_i   (mul_free),     .stall_o     (stall_o),
        .rs1_addr_o   (rs1_addr),     .rs2_addr_o  (rs2_addr),
        .rd_addr_o    (rd_addr),      .alu_alloc_o (alu_alloc),
        .mul_alloc_o  (mul_alloc),    .alu_op_o    (dec_op),
        .opa_o        (opa),          .opa_rdy_o   (opa_rdy),
        .opa_tag_o    (opa_tag),      .opb_o       (opb),
        .opb_rdy_o    (opb_rdy),      .opb_tag_o   (opb_tag),
        .set_busy_o   (set_busy)
    );

    rs_issue alu_rs (
        .clk_i       (clk_i),       .reset_i       (reset_i),
        .alloc_i     (alu_alloc),   .alu_op_i      (dec_op),
        .opa_i       (opa),         .opa_rdy_i     (opa_rdy),
        .opa_tag_i   (opa_tag),     .opb_i         (opb),
        .opb_rdy_i   (opb_rdy),     .opb_tag_i     (opb_tag),
        .rd_i        (rd_addr),     .cdb_valid_i   (cdb_valid_o),
        .cdb_tag_i   (cdb_tag_o),   .cdb_data_i    (cdb_data_o),
        .issue_block_i (mul_near_done),
        .free_o      (alu_free),    .issue_o       (alu_issue),
        .alu_op_o    (alu_op),      .opa_o         (alu_a),
        .opb_o       (alu_b),       .rd_o          (alu_rd)
    );

    // Multiplier station ignores the ALU operation field
    rs_issue mul_rs (
        .clk_i       (clk_i),       .reset_i       (reset_i),
        .alloc_i     (mul_alloc),   .alu_op_i      (dec_op),
        .opa_i       (opa),         .opa_rdy_i     (opa_rdy),
        .opa_tag_i   (opa_tag),     .opb_i         (opb),
        .opb_rdy_i   (opb_rdy),     .opb_tag_i     (opb_tag),
        .rd_i        (rd_addr),     .cdb_valid_i   (cdb_valid_o),
        .cdb_tag_i   (cdb_tag_o),   .cdb_data_i    (cdb_data_o),
        .issue_block_i (1'b0),
        .free_o      (mul_free),    .issue_o       (mul_issue),
        .alu_op_o    (),            .opa_o         (mul_a),
        .opb_o       (mul_b),       .rd_o          (mul_rd)
    );

    fu_execute u_execute (
        .clk_i       (clk_i),       .reset_i         (reset_i),
        .alu_issue_i (alu_issue),   .alu_op_i        (alu_op),
        .alu_a_i     (alu_a),       .alu_b_i         (alu_b),
        .alu_rd_i    (alu_rd),      .mul_issue_i     (mul_issue),
        .mul_a_i     (mul_a),       .mul_b_i         (mul_b),
        .mul_rd_i    (mul_rd),      .mul_near_done_o (mul_near_done),
        .res_valid_o (res_valid),   .res_tag_o       (res_tag),
        .res_data_o  (res_data)
    );

    result_regfile u_result (
        .clk_i       (clk_i),       .reset_i        (reset_i),
        .res_valid_i (res_valid),   .res_tag_i      (res_tag),
        .res_data_i  (res_data),    .set_busy_i     (set_busy),
        .set_busy_tag_i (rd_addr),
        .rs1_addr_i  (rs1_addr),    .rs2_addr_i     (rs2_addr),
        .rd_addr_i   (rd_addr),     .rs1_val_o      (rs1_val),
        .rs1_rdy_o   (rs1_rdy),     .rs2_val_o      (rs2_val),
        .rs2_rdy_o   (rs2_rdy),     .busy_rd_o      (busy_rd),
        .cdb_valid_o (cdb_valid_o), .cdb_tag_o      (cdb_tag_o),
        .cdb_data_o  (cdb_data_o)
    );

endmodule

//--- source/result_regfile.sv
// Register file with busy bits, CDB broadcast and forwarding on read
`timescale 1ns/1ps
`include "ooo_issue_cfg.svh"
module result_regfile (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        res_valid_i,
    input  logic [4:0]  res_tag_i,
    input  logic [31:0] res_data_i,
    input  logic        set_busy_i,
    input  logic [4:0]  set_busy_tag_i,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    input  logic [4:0]  rd_addr_i,
    output logic [31:0] rs1_val_o,
    output logic        rs1_rdy_o,
    output logic [31:0] rs2_val_o,
    output logic        rs2_rdy_o,
    output logic        busy_rd_o,
    output logic        cdb_valid_o,
    output logic [4:0]  cdb_tag_o,
    output logic [31:0] cdb_data_o
);
    logic [31:0]              regs [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0] busy;

    // x0 reads as zero, then CDB, then the stored value
    function automatic logic [32:0] read_port(input logic [4:0] addr);
        logic [32:0] r;
        if (addr == 5'd0) begin
            r = {1'b1, 32'h0};
        end else if (res_valid_i && res_tag_i == addr) begin
            r = {1'b1, res_data_i};
        end else begin
            r = {!busy[addr], regs[addr]};
        end
        return r;
    endfunction

    always_comb begin
        {rs1_rdy_o, rs1_val_o} = read_port(rs1_addr_i);
        {rs2_rdy_o, rs2_val_o} = read_port(rs2_addr_i);
    end

    assign busy_rd_o   = busy[rd_addr_i];
    assign cdb_valid_o = res_valid_i;
    assign cdb_tag_o   = res_tag_i;
    assign cdb_data_o  = res_data_i;

    // Decode never sets a tag that is still busy
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy <= '0;
        end else begin
            if (res_valid_i) busy[res_tag_i] <= 1'b0;
            if (set_busy_i) busy[set_busy_tag_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (res_valid_i) regs[res_tag_i] <= res_data_i;
    end

endmodule

//--- source/fu_execute.sv
// Functional units, single-cycle ALU and pipelined 32-bit multiplier
`timescale 1ns/1ps
`include "ooo_issue_cfg.svh"
module fu_execute import ooo_issue_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        alu_issue_i,
    input  alu_op_e     alu_op_i,
    input  logic [31:0] alu_a_i,
    input  logic [31:0] alu_b_i,
    input  logic [4:0]  alu_rd_i,
    input  logic        mul_issue_i,
    input  logic [31:0] mul_a_i,
    input  logic [31:0] mul_b_i,
    input  logic [4:0]  mul_rd_i,
    output logic        mul_near_done_o,
    output logic        res_valid_o,
    output logic [4:0]  res_tag_o,
    output logic [31:0] res_data_o
);
    localparam int STAGES = `OOO_MUL_STAGES;

    logic              alu_v_q;
    logic [4:0]        alu_tag_q;
    logic [31:0]       alu_res_q;
    logic [31:0]       alu_res;
    logic [31:0]       mul_lo;
    logic [STAGES-1:0] mul_v_q;
    logic [4:0]        mul_tag_q [STAGES];
    logic [31:0]       mul_p_q   [STAGES];

    always_comb begin
        case (alu_op_i)
            ALU_SUB: alu_res = alu_a_i - alu_b_i;
            ALU_AND: alu_res = alu_a_i & alu_b_i;
            ALU_OR:  alu_res = alu_a_i | alu_b_i;
            ALU_XOR: alu_res = alu_a_i ^ alu_b_i;
            default: alu_res = alu_a_i + alu_b_i;
        endcase
    end

    // Only the low word of the product is kept
    assign mul_lo = mul_a_i * mul_b_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alu_v_q <= 1'b0;
            mul_v_q <= '0;
        end else begin
            alu_v_q <= alu_issue_i;
            mul_v_q <= {mul_v_q[STAGES-2:0], mul_issue_i};
        end
    end

    always_ff @(posedge clk_i) begin
        alu_tag_q    <= alu_rd_i;
        alu_res_q    <= alu_res;
        mul_tag_q[0] <= mul_rd_i;
        mul_p_q[0]   <= mul_lo;
        for (int s = 1; s < STAGES; s++) begin
            mul_tag_q[s] <= mul_tag_q[s-1];
            mul_p_q[s]   <= mul_p_q[s-1];
        end
    end

    // ALU station holds off while this is set
    assign mul_near_done_o = mul_v_q[STAGES-2];

    assign res_valid_o = alu_v_q || mul_v_q[STAGES-1];
    assign res_tag_o   = mul_v_q[STAGES-1] ? mul_tag_q[STAGES-1] : alu_tag_q;
    assign res_data_o  = mul_v_q[STAGES-1] ? mul_p_q[STAGES-1] : alu_res_q;

endmodule

//--- source/rs_issue.sv
// Reservation station, allocates into the first free slot and issues the oldest ready one
`timescale 1ns/1ps
`include "ooo_issue_cfg.svh"
module rs_issue import ooo_issue_pkg::*; #(
    parameter int RS_SIZE = `OOO_RS_SIZE
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        alloc_i,
    input  alu_op_e     alu_op_i,
    input  logic [31:0] opa_i,
    input  logic        opa_rdy_i,
    input  logic [4:0]  opa_tag_i,
    input  logic [31:0] opb_i,
    input  logic        opb_rdy_i,
    input  logic [4:0]  opb_tag_i,
    input  logic [4:0]  rd_i,
    input  logic        cdb_valid_i,
    input  logic [4:0]  cdb_tag_i,
    input  logic [31:0] cdb_data_i,
    input  logic        issue_block_i,
    output logic        free_o,
    output logic        issue_o,
    output alu_op_e     alu_op_o,
    output logic [31:0] opa_o,
    output logic [31:0] opb_o,
    output logic [4:0]  rd_o
);
    localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;
    localparam int AGE_W = IDX_W + 2;

    logic [RS_SIZE-1:0] slot_free;
    logic [RS_SIZE-1:0] slot_ready;
    logic [RS_SIZE-1:0] slot_alloc;
    logic [RS_SIZE-1:0] slot_issue;
    logic [AGE_W-1:0]   slot_age [RS_SIZE];
    alu_op_e            slot_op  [RS_SIZE];
    logic [31:0]        slot_a   [RS_SIZE];
    logic [31:0]        slot_b   [RS_SIZE];
    logic [4:0]         slot_rd  [RS_SIZE];
    logic [IDX_W-1:0]   sel_idx;
    logic [AGE_W-1:0]   best_age;
    logic               found;

    // Scan downward so the lowest free index wins
    always_comb begin
        slot_alloc = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (slot_free[i]) begin
                slot_alloc    = '0;
                slot_alloc[i] = alloc_i;
            end
        end
    end

    // Oldest ready slot, strict compare keeps ties at the lower index
    always_comb begin
        found    = 1'b0;
        sel_idx  = '0;
        best_age = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (slot_ready[i] && (!found || slot_age[i] > best_age)) begin
                found    = 1'b1;
                sel_idx  = IDX_W'(i);
                best_age = slot_age[i];
            end
        end
    end

    assign issue_o    = found && !issue_block_i;
    assign slot_issue = issue_o ? (RS_SIZE'(1) << sel_idx) : '0;
    assign free_o     = |slot_free;

    assign alu_op_o = slot_op[sel_idx];
    assign opa_o    = slot_a[sel_idx];
    assign opb_o    = slot_b[sel_idx];
    assign rd_o     = slot_rd[sel_idx];

    for (genvar g = 0; g < RS_SIZE; g++) begin : g_slot
        rs_entry #(.AGE_W(AGE_W)) u_entry (
            .clk_i       (clk_i),
            .reset_i     (reset_i),
            .alloc_i     (slot_alloc[g]),
            .issue_i     (slot_issue[g]),
            .alu_op_i    (alu_op_i),
            .opa_i       (opa_i),
            .opa_rdy_i   (opa_rdy_i),
            .opa_tag_i   (opa_tag_i),
            .opb_i       (opb_i),
            .opb_rdy_i   (opb_rdy_i),
            .opb_tag_i   (opb_tag_i),
            .rd_i        (rd_i),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .free_o      (slot_free[g]),
            .ready_o     (slot_ready[g]),
            .age_o       (slot_age[g]),
            .alu_op_o    (slot_op[g]),
            .opa_o       (slot_a[g]),
            .opb_o       (slot_b[g]),
            .rd_o        (slot_rd[g])
        );
    end

endmodule

//--- source/rs_entry.sv
// Single reservation station slot with operand capture and CDB wakeup
`timescale 1ns/1ps
module rs_entry import ooo_issue_pkg::*; #(
    parameter int AGE_W = 4
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             alloc_i,
    input  logic             issue_i,
    input  alu_op_e          alu_op_i,
    input  logic [31:0]      opa_i,
    input  logic             opa_rdy_i,
    input  logic [4:0]       opa_tag_i,
    input  logic [31:0]      opb_i,
    input  logic             opb_rdy_i,
    input  logic [4:0]       opb_tag_i,
    input  logic [4:0]       rd_i,
    input  logic             cdb_valid_i,
    input  logic [4:0]       cdb_tag_i,
    input  logic [31:0]      cdb_data_i,
    output logic             free_o,
    output logic             ready_o,
    output logic [AGE_W-1:0] age_o,
    output alu_op_e          alu_op_o,
    output logic [31:0]      opa_o,
    output logic [31:0]      opb_o,
    output logic [4:0]       rd_o
);
    logic       valid_q;
    logic       opa_rdy_q;
    logic       opb_rdy_q;
    logic [4:0] opa_tag_q;
    logic [4:0] opb_tag_q;

    assign free_o  = !valid_q;
    assign ready_o = valid_q && opa_rdy_q && opb_rdy_q;

    // Occupancy and age
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            age_o   <= '0;
        end else if (alloc_i) begin
            valid_q <= 1'b1;
            age_o   <= '0;
        end else if (issue_i) begin
            valid_q <= 1'b0;
        end else if (valid_q && age_o != '1) begin
            age_o <= age_o + 1'b1;
        end
    end

    // Operand capture, then snoop the CDB for whatever is missing
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            alu_op_o  <= alu_op_i;
            opa_o     <= opa_i;
            opa_rdy_q <= opa_rdy_i;
            opa_tag_q <= opa_tag_i;
            opb_o     <= opb_i;
            opb_rdy_q <= opb_rdy_i;
            opb_tag_q <= opb_tag_i;
            rd_o      <= rd_i;
        end else begin
            if (!opa_rdy_q && cdb_valid_i && cdb_tag_i == opa_tag_q) begin
                opa_o     <= cdb_data_i;
                opa_rdy_q <= 1'b1;
            end
            if (!opb_rdy_q && cdb_valid_i && cdb_tag_i == opb_tag_q) begin
                opb_o     <= cdb_data_i;
                opb_rdy_q <= 1'b1;
            end
        end
    end

endmodule

//--- source/inst_decode.sv
// Instruction decode, operand lookup and station allocation or stall
`timescale 1ns/1ps
module inst_decode import ooo_issue_pkg::*; (
    input  logic        inst_valid_i,
    input  rv_inst_u    inst_i,
    input  logic [31:0] rs1_val_i,
    input  logic        rs1_rdy_i,
    input  logic [31:0] rs2_val_i,
    input  logic        rs2_rdy_i,
    input  logic        busy_rd_i,
    input  logic        alu_free_i,
    input  logic        mul_free_i,
    output logic        stall_o,
    output logic [4:0]  rs1_addr_o,
    output logic [4:0]  rs2_addr_o,
    output logic [4:0]  rd_addr_o,
    output logic        alu_alloc_o,
    output logic        mul_alloc_o,
    output alu_op_e     alu_op_o,
    output logic [31:0] opa_o,
    output logic        opa_rdy_o,
    output logic [4:0]  opa_tag_o,
    output logic [31:0] opb_o,
    output logic        opb_rdy_o,
    output logic [4:0]  opb_tag_o,
    output logic        set_busy_o
);
    fu_class_e   cls;
    logic        is_imm;
    logic        legal;
    logic        no_slot;
    logic [31:0] imm_sext;

    // Class and operation from opcode, funct7 and funct3
    always_comb begin
        cls = FU_NONE;
        alu_op_o = ALU_ADD;
        is_imm = 1'b0;
        if (inst_i.r.opcode == OPC_OP) begin
            case ({inst_i.r.funct7, inst_i.r.funct3})
                {7'b0000000, 3'b000}: cls = FU_ALU;
                {7'b0100000, 3'b000}: begin
                    cls = FU_ALU;
                    alu_op_o = ALU_SUB;
                end
                {7'b0000000, 3'b100}: begin
                    cls = FU_ALU;
                    alu_op_o = ALU_XOR;
                end
                {7'b0000000, 3'b110}: begin
                    cls = FU_ALU;
                    alu_op_o = ALU_OR;
                end
                {7'b0000000, 3'b111}: begin
                    cls = FU_ALU;
                    alu_op_o = ALU_AND;
                end
                {7'b0000001, 3'b000}: cls = FU_MUL;
                default: cls = FU_NONE;
            endcase
        end else if (inst_i.i.opcode == OPC_OP_IMM && inst_i.i.funct3 == 3'b000) begin
            // ADDI
            cls = FU_ALU;
            is_imm = 1'b1;
        end
    end

    assign imm_sext   = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
    assign rs1_addr_o = inst_i.r.rs1;
    assign rs2_addr_o = inst_i.r.rs2;
    assign rd_addr_o  = inst_i.r.rd;

    // Illegal opcodes and writes to x0 pass through as no-ops
    assign legal   = (cls != FU_NONE) && (inst_i.r.rd != 5'd0);
    assign no_slot = (cls == FU_ALU) ? !alu_free_i : !mul_free_i;
    assign stall_o = inst_valid_i && legal && (no_slot || busy_rd_i);

    assign alu_alloc_o = inst_valid_i && legal && !stall_o && (cls == FU_ALU);
    assign mul_alloc_o = inst_valid_i && legal && !stall_o && (cls == FU_MUL);
    assign set_busy_o  = alu_alloc_o || mul_alloc_o;

    assign opa_o     = rs1_val_i;
    assign opa_rdy_o = rs1_rdy_i;
    assign opa_tag_o = inst_i.r.rs1;
    // Immediate operand is always ready
    assign opb_o     = is_imm ? imm_sext : rs2_val_i;
    assign opb_rdy_o = is_imm || rs2_rdy_i;
    assign opb_tag_o = inst_i.r.rs2;

endmodule

//--- source/ooo_issue_pkg.sv
// Shared instruction, unit class and ALU operation types for the issue slice
package ooo_issue_pkg;

    // RV32 major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_t;

    // Same word, register form or immediate form
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
    } rv_inst_u;

    typedef enum logic [1:0] {FU_NONE, FU_ALU, FU_MUL} fu_class_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

endpackage

//--- source/ooo_issue_cfg.svh
// Build-time sizing for the out-of-order issue slice
`ifndef OOO_ISSUE_CFG_SVH
`define OOO_ISSUE_CFG_SVH

// Slots per reservation station
`define OOO_RS_SIZE 4

// Multiplier latency in cycles, at least 2
`define OOO_MUL_STAGES 3

// Architectural registers, tags are 5 bits wide
`define OOO_NUM_REGS 32

`endif
